// File: mem_if_settings.svh
`ifndef MEM_IF_SETTINGS_SVH
`define MEM_IF_SETTINGS_SVH

//////////////////////////////
// data path geometry
//////////////////////////////

// bytes per data word
`define MEM_DATA_BYTES 8

// words held in on-chip storage
`define MEM_DEPTH_WORDS 256

//////////////////////////////
// command word fields
//////////////////////////////

// byte address width
`define MEM_ADDR_BITS 32

// bytes to transfer
`define MEM_BTT_BITS 23

// command tag, echoed in status
`define MEM_TAG_BITS 4

`endif

// File: mem_if_pkg.sv
`include "mem_if_settings.svh"

package mem_if_pkg;

    // byte lanes per word, log2
    localparam int BYTE_SEL_BITS = $clog2(`MEM_DATA_BYTES);

    typedef logic [`MEM_DATA_BYTES*8-1:0] word_t;
    typedef logic [`MEM_DATA_BYTES-1:0] keep_t;
    typedef logic [$clog2(`MEM_DEPTH_WORDS)-1:0] word_idx_t;
    // ceil(btt / 8) needs one bit more than btt >> 3
    typedef logic [`MEM_BTT_BITS-BYTE_SEL_BITS:0] word_cnt_t;

    //////////////////////////////
    // stream payloads
    //////////////////////////////

    // read and write commands share this 72-bit layout
    typedef struct packed {
        logic [3:0]               rsvd;
        logic [`MEM_TAG_BITS-1:0] tag;
        logic [`MEM_ADDR_BITS-1:0] addr;
        logic [8:0]               ctrl;
        logic [`MEM_BTT_BITS-1:0] btt;
    } dm_cmd_t;

    typedef struct packed {
        logic                     ok;
        logic                     slv_err;
        logic                     dec_err;
        logic                     spare;
        logic [`MEM_TAG_BITS-1:0] tag;
    } dm_sts_t;

    typedef struct packed {
        word_t data;
        keep_t keep;
        logic  last;
    } axis_beat_t;

    // write engine to store
    typedef struct packed {
        logic      en;
        word_idx_t index;
        word_t     data;
        keep_t     be;
    } wr_port_t;

    // command after decode, held by each engine for the transfer
    typedef struct packed {
        logic [`MEM_TAG_BITS-1:0] tag;
        word_idx_t                start;
        word_cnt_t                count;
        keep_t                    last_keep;
        logic                     slv_err;
        logic                     dec_err;
    } cmd_info_t;

    function automatic cmd_info_t decode_cmd(dm_cmd_t cmd);
        cmd_info_t                 info;
        logic [BYTE_SEL_BITS-1:0]  rem;
        logic [`MEM_ADDR_BITS:0]   end_word;
        rem            = cmd.btt[BYTE_SEL_BITS-1:0];
        info.tag       = cmd.tag;
        info.start     = word_idx_t'(cmd.addr >> BYTE_SEL_BITS);
        info.count     = word_cnt_t'(cmd.btt >> BYTE_SEL_BITS) + word_cnt_t'(|rem);
        info.last_keep = (rem == '0) ? '1 : keep_t'((32'd1 << rem) - 32'd1);
        // one past the last word touched
        end_word       = (`MEM_ADDR_BITS+1)'(cmd.addr >> BYTE_SEL_BITS)
                       + (`MEM_ADDR_BITS+1)'(info.count);
        info.dec_err   = (cmd.btt == '0);
        info.slv_err   = !info.dec_err && (end_word > (`MEM_ADDR_BITS+1)'(`MEM_DEPTH_WORDS));
        return info;
    endfunction

    function automatic dm_sts_t make_status(cmd_info_t info);
        dm_sts_t sts;
        sts.ok      = !(info.slv_err || info.dec_err);
        sts.slv_err = info.slv_err;
        sts.dec_err = info.dec_err;
        sts.spare   = 1'b0;
        sts.tag     = info.tag;
        return sts;
    endfunction

endpackage

// File: mem_write_engine.sv
`timescale 1ns/1ps
`include "mem_if_settings.svh"

module mem_write_engine
    import mem_if_pkg::*;
(
    input  logic       c0_ui_clk,
    input  logic       arst_n,

    input  dm_cmd_t    write_cmd,
    input  logic       write_cmd_valid,
    output logic       write_cmd_ready,

    input  axis_beat_t write_data,
    input  logic       write_data_valid,
    output logic       write_data_ready,

    output dm_sts_t    write_sts,
    output logic       write_sts_valid,
    input  logic       write_sts_ready,

    output wr_port_t   wr_port
);

    cmd_info_t cmd_dec;
    cmd_info_t info;
    word_idx_t wr_index;
    word_cnt_t words_left;
    logic      data_phase;
    logic      cmd_fire;
    logic      beat_fire;

    assign cmd_dec = decode_cmd(write_cmd);

    // new command only when idle and the last status has gone
    assign write_cmd_ready  = !data_phase && !write_sts_valid;
    assign write_data_ready = data_phase;
    assign cmd_fire         = write_cmd_valid && write_cmd_ready;
    assign beat_fire        = write_data_valid && data_phase;
    assign write_sts        = make_status(info);

    //////////////////////////////
    // control
    //////////////////////////////

    always_ff @(posedge c0_ui_clk or negedge arst_n) begin
        if (!arst_n) begin
            data_phase      <= 1'b0;
            write_sts_valid <= 1'b0;
            words_left      <= '0;
        end else begin
            if (cmd_fire) begin
                if (cmd_dec.dec_err) begin
                    // nothing to move, report straight away
                    write_sts_valid <= 1'b1;
                end else begin
                    data_phase <= 1'b1;
                    words_left <= cmd_dec.count;
                end
            end
            if (beat_fire) begin
                words_left <= words_left - 1'b1;
                if (words_left == 1) begin
                    data_phase      <= 1'b0;
                    write_sts_valid <= 1'b1;
                end
            end
            if (write_sts_valid && write_sts_ready) begin
                write_sts_valid <= 1'b0;
            end
        end
    end

    // latched command and running word index
    always_ff @(posedge c0_ui_clk) begin
        if (cmd_fire) begin
            info     <= cmd_dec;
            wr_index <= cmd_dec.start;
        end else if (beat_fire) begin
            wr_index <= wr_index + 1'b1;
        end
    end

    //////////////////////////////
    // store port
    //////////////////////////////

    // beats of an out-of-range command are dropped
    always_comb begin
        wr_port.en    = beat_fire && !info.slv_err;
        wr_port.index = wr_index;
        wr_port.data  = write_data.data;
        wr_port.be    = write_data.keep;
    end

    // source framing must agree with the word count from the command
    a_last_matches_count: assert property (
        @(posedge c0_ui_clk) disable iff (!arst_n)
        beat_fire |-> (write_data.last == (words_left == 1))
    );

endmodule

// File: word_store.sv
`timescale 1ns/1ps
`include "mem_if_settings.svh"

module word_store
    import mem_if_pkg::*;
(
    input  logic      c0_ui_clk,
    input  wr_port_t  wr_port,
    input  logic      rd_en,
    input  word_idx_t rd_index,
    output word_t     rd_data
);

    word_t mem [`MEM_DEPTH_WORDS];

    //////////////////////////////
    // write port
    //////////////////////////////

    // per-byte enables from keep
    always_ff @(posedge c0_ui_clk) begin
        if (wr_port.en) begin
            for (int b = 0; b < `MEM_DATA_BYTES; b++) begin
                if (wr_port.be[b]) begin
                    mem[wr_port.index][b*8 +: 8] <= wr_port.data[b*8 +: 8];
                end
            end
        end
    end

    //////////////////////////////
    // read port
    //////////////////////////////

    // registered read, old data on a same-word collision
    always_ff @(posedge c0_ui_clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_index];
        end
    end

endmodule

// File: mem_read_engine.sv
`timescale 1ns/1ps

module mem_read_engine
    import mem_if_pkg::*;
(
    input  logic       c0_ui_clk,
    input  logic       arst_n,

    input  dm_cmd_t    read_cmd,
    input  logic       read_cmd_valid,
    output logic       read_cmd_ready,

    output axis_beat_t read_data,
    output logic       read_data_valid,
    input  logic       read_data_ready,

    output dm_sts_t    read_sts,
    output logic       read_sts_valid,
    input  logic       read_sts_ready,

    output logic       rd_en,
    output word_idx_t  rd_index,
    input  word_t      rd_data
);

    cmd_info_t  cmd_dec;
    cmd_info_t  info;
    logic       active;
    word_cnt_t  issue_left;
    word_idx_t  issue_idx;
    logic       issue;
    logic       issue_last;
    logic       cmd_fire;

    // read in flight, keep and last travel with it
    logic       inflight;
    keep_t      inflight_keep;
    logic       inflight_last;

    // two-entry output queue
    axis_beat_t q [2];
    logic       q_head;
    logic       q_tail;
    logic [1:0] q_count;
    logic [1:0] q_used;
    logic       push;
    logic       pop;

    assign cmd_dec        = decode_cmd(read_cmd);
    assign read_cmd_ready = !active && !read_sts_valid;
    assign cmd_fire       = read_cmd_valid && read_cmd_ready;
    assign read_sts       = make_status(info);

    //////////////////////////////
    // read issue
    //////////////////////////////

    // queue slots taken, the read in flight included
    assign q_used     = q_count + 2'(inflight);
    assign pop        = read_data_valid && read_data_ready;
    assign push       = inflight;
    assign issue      = active && (issue_left != '0) && read_data_ready
                        && ((q_used < 2'd2) || pop);
    assign issue_last = (issue_left == 1);

    // out-of-range commands still count words but skip the array
    assign rd_en    = issue && !info.slv_err;
    assign rd_index = issue_idx;

    assign read_data       = q[q_head];
    assign read_data_valid = (q_count != 2'd0);

    always_ff @(posedge c0_ui_clk or negedge arst_n) begin
        if (!arst_n) begin
            active         <= 1'b0;
            read_sts_valid <= 1'b0;
            issue_left     <= '0;
            inflight       <= 1'b0;
            q_head         <= 1'b0;
            q_tail         <= 1'b0;
            q_count        <= 2'd0;
        end else begin
            if (cmd_fire) begin
                if (cmd_dec.dec_err) begin
                    read_sts_valid <= 1'b1;
                end else begin
                    active     <= 1'b1;
                    issue_left <= cmd_dec.count;
                end
            end
            if (issue) begin
                issue_left <= issue_left - 1'b1;
            end
            inflight <= issue;
            if (push) begin
                q_tail <= !q_tail;
            end
            if (pop) begin
                q_head <= !q_head;
                if (read_data.last) begin
                    active         <= 1'b0;
                    read_sts_valid <= 1'b1;
                end
            end
            q_count <= q_count + 2'(push) - 2'(pop);
            if (read_sts_valid && read_sts_ready) begin
                read_sts_valid <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // payload
    //////////////////////////////

    always_ff @(posedge c0_ui_clk) begin
        if (cmd_fire) begin
            info      <= cmd_dec;
            issue_idx <= cmd_dec.start;
        end else if (issue) begin
            issue_idx <= issue_idx + 1'b1;
        end
        inflight_keep <= issue_last ? info.last_keep : '1;
        inflight_last <= issue_last;
        if (push) begin
            q[q_tail] <= '{data: info.slv_err ? '0 : rd_data,
                           keep: inflight_keep,
                           last: inflight_last};
        end
    end

    // head beat held while the sink stalls
    a_stall_stable: assert property (
        @(posedge c0_ui_clk) disable iff (!arst_n)
        (read_data_valid && !read_data_ready) |=> (read_data_valid && $stable(read_data))
    );

endmodule

// File: mem_if_top.sv
`timescale 1ns/1ps

module mem_if_top
    import mem_if_pkg::*;
(
    input  logic       c0_ui_clk,
    input  logic       arst_n,

    // write side
    input  dm_cmd_t    write_cmd,
    input  logic       write_cmd_valid,
    output logic       write_cmd_ready,
    input  axis_beat_t write_data,
    input  logic       write_data_valid,
    output logic       write_data_ready,
    output dm_sts_t    write_sts,
    output logic       write_sts_valid,
    input  logic       write_sts_ready,

    // read side
    input  dm_cmd_t    read_cmd,
    input  logic       read_cmd_valid,
    output logic       read_cmd_ready,
    output axis_beat_t read_data,
    output logic       read_data_valid,
    input  logic       read_data_ready,
    output dm_sts_t    read_sts,
    output logic       read_sts_valid,
    input  logic       read_sts_ready
);

    wr_port_t  wr_port;
    logic      rd_en;
    word_idx_t rd_index;
    word_t     rd_data;

    mem_write_engine u_write_engine (
        .c0_ui_clk        (c0_ui_clk),
        .arst_n           (arst_n),
        .write_cmd        (write_cmd),
        .write_cmd_valid  (write_cmd_valid),
        .write_cmd_ready  (write_cmd_ready),
        .write_data       (write_data),
        .write_data_valid (write_data_valid),
        .write_data_ready (write_data_ready),
        .write_sts        (write_sts),
        .write_sts_valid  (write_sts_valid),
        .write_sts_ready  (write_sts_ready),
        .wr_port          (wr_port)
    );

    // on-chip storage in place of the DDR3 channel
    word_store u_word_store (
        .c0_ui_clk (c0_ui_clk),
        .wr_port   (wr_port),
        .rd_en     (rd_en),
        .rd_index  (rd_index),
        .rd_data   (rd_data)
    );

    mem_read_engine u_read_engine (
        .c0_ui_clk       (c0_ui_clk),
        .arst_n          (arst_n),
        .read_cmd        (read_cmd),
        .read_cmd_valid  (read_cmd_valid),
        .read_cmd_ready  (read_cmd_ready),
        .read_data       (read_data),
        .read_data_valid (read_data_valid),
        .read_data_ready (read_data_ready),
        .read_sts        (read_sts),
        .read_sts_valid  (read_sts_valid),
        .read_sts_ready  (read_sts_ready),
        .rd_en           (rd_en),
        .rd_index        (rd_index),
        .rd_data         (rd_data)
    );

endmodule

// File: tb_mem_if.sv
`timescale 1ns/1ps
`include "mem_if_settings.svh"

module tb_mem_if
    import mem_if_pkg::*;
();

    // about four times the length of the sequence below
    localparam int MAX_CYCLES  = 4000;
    localparam int MODEL_BYTES = `MEM_DEPTH_WORDS * `MEM_DATA_BYTES;

    logic       c0_ui_clk = 1'b0;
    logic       arst_n;
    dm_cmd_t    write_cmd;
    logic       write_cmd_valid;
    logic       write_cmd_ready;
    axis_beat_t write_data;
    logic       write_data_valid;
    logic       write_data_ready;
    dm_sts_t    write_sts;
    logic       write_sts_valid;
    logic       write_sts_ready;
    dm_cmd_t    read_cmd;
    logic       read_cmd_valid;
    logic       read_cmd_ready;
    axis_beat_t read_data;
    logic       read_data_valid;
    logic       read_data_ready;
    dm_sts_t    read_sts;
    logic       read_sts_valid;
    logic       read_sts_ready;

    // reference byte model and expected responses
    logic [7:0] model [MODEL_BYTES];
    axis_beat_t exp_beat_q [$];
    dm_sts_t    exp_wsts_q [$];
    dm_sts_t    exp_rsts_q [$];
    axis_beat_t exp_beat;
    dm_sts_t    exp_wsts;
    dm_sts_t    exp_rsts;
    dm_sts_t    sts;
    int         wr_word;
    logic       wr_skip;
    int         wsts_done = 0;
    int         rsts_done = 0;
    int         cycles = 0;
    logic       rand_ready = 1'b0;

    mem_if_top DUT (.*);

    always #2 c0_ui_clk = ~c0_ui_clk;

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic step();
        @(posedge c0_ui_clk);
        #0.5;
    endtask

    function automatic dm_sts_t expect_status(dm_cmd_t cmd);
        dm_sts_t     s;
        int unsigned words;
        int unsigned last_word;
        words     = (int'(cmd.btt) + 7) / 8;
        last_word = (cmd.addr >> 3) + words - 1;
        s.dec_err = (cmd.btt == '0);
        // last word index at the depth or beyond is out of range
        s.slv_err = !s.dec_err && (last_word >= `MEM_DEPTH_WORDS);
        s.ok      = !(s.slv_err || s.dec_err);
        s.spare   = 1'b0;
        s.tag     = cmd.tag;
        return s;
    endfunction

    // beats a read command should deliver, from the byte model
    function automatic void queue_read_beats(dm_cmd_t cmd, logic zero_data);
        axis_beat_t beat;
        int         words;
        int         start;
        int         rem;
        words = (int'(cmd.btt) + 7) / 8;
        start = int'(cmd.addr >> 3);
        rem   = int'(cmd.btt) % 8;
        for (int w = 0; w < words; w++) begin
            beat.keep = (w == words - 1 && rem != 0) ? 8'((1 << rem) - 1) : '1;
            beat.last = (w == words - 1);
            for (int b = 0; b < 8; b++) begin
                beat.data[b*8 +: 8] = zero_data ? 8'h00 : model[(start + w) * 8 + b];
            end
            exp_beat_q.push_back(beat);
        end
    endfunction

    //////////////////////////////
    // monitor and model update
    //////////////////////////////

    always @(posedge c0_ui_clk) begin
        if (arst_n) begin
            if (write_cmd_valid && write_cmd_ready) begin
                sts = expect_status(write_cmd);
                exp_wsts_q.push_back(sts);
                wr_word = int'(write_cmd.addr >> 3);
                wr_skip = sts.slv_err;
            end
            if (write_data_valid && write_data_ready) begin
                for (int b = 0; b < 8; b++) begin
                    if (!wr_skip && write_data.keep[b]) begin
                        model[wr_word * 8 + b] = write_data.data[b*8 +: 8];
                    end
                end
                wr_word++;
            end
            if (write_sts_valid && write_sts_ready) begin
                void'(exp_wsts_q.pop_front());
                wsts_done <= wsts_done + 1;
            end
            if (read_cmd_valid && read_cmd_ready) begin
                sts = expect_status(read_cmd);
                exp_rsts_q.push_back(sts);
                queue_read_beats(read_cmd, sts.slv_err);
            end
            if (read_data_valid && read_data_ready) begin
                void'(exp_beat_q.pop_front());
            end
            if (read_sts_valid && read_sts_ready) begin
                void'(exp_rsts_q.pop_front());
                rsts_done <= rsts_done + 1;
            end
        end
        exp_beat <= (exp_beat_q.size() != 0) ? exp_beat_q[0] : '0;
        exp_wsts <= (exp_wsts_q.size() != 0) ? exp_wsts_q[0] : '0;
        exp_rsts <= (exp_rsts_q.size() != 0) ? exp_rsts_q[0] : '0;
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    // data, keep and last in one compare
    a_read_beat: assert property (
        @(posedge c0_ui_clk) disable iff (!arst_n)
        (read_data_valid && read_data_ready) |-> (read_data == exp_beat)
    ) else begin
        $display("error %0t read_data expected %h actual %h",
                 $time, $sampled(exp_beat), $sampled(read_data));
        abort_run();
    end

    a_write_sts: assert property (
        @(posedge c0_ui_clk) disable iff (!arst_n)
        (write_sts_valid && write_sts_ready) |-> (write_sts == exp_wsts)
    ) else begin
        $display("error %0t write_sts expected %h actual %h",
                 $time, $sampled(exp_wsts), $sampled(write_sts));
        abort_run();
    end

    a_read_sts: assert property (
        @(posedge c0_ui_clk) disable iff (!arst_n)
        (read_sts_valid && read_sts_ready) |-> (read_sts == exp_rsts)
    ) else begin
        $display("error %0t read_sts expected %h actual %h",
                 $time, $sampled(exp_rsts), $sampled(read_sts));
        abort_run();
    end

    a_stall_hold: assert property (
        @(posedge c0_ui_clk) disable iff (!arst_n)
        (read_data_valid && !read_data_ready) |=> (read_data_valid && $stable(read_data))
    ) else begin
        $display("read_data beat dropped or changed while stalled at %0t", $time);
        abort_run();
    end

    always @(posedge c0_ui_clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            abort_run();
        end
    end

    // sink readies, randomly gapped when enabled
    initial begin
        read_data_ready = 1'b1;
        write_sts_ready = 1'b1;
        read_sts_ready  = 1'b1;
        forever begin
            step();
            read_data_ready = !rand_ready || (($urandom % 4) != 0);
            write_sts_ready = !rand_ready || (($urandom % 2) == 0);
            read_sts_ready  = !rand_ready || (($urandom % 2) == 0);
        end
    end

    task automatic write_burst(input logic [31:0] addr, input int btt,
                               input logic [`MEM_TAG_BITS-1:0] tag,
                               input logic rand_keep, input logic fill);
        axis_beat_t beat;
        int         words;
        int         target;
        target          = wsts_done + 1;
        words           = (btt + 7) / 8;
        write_cmd       = '0;
        write_cmd.tag   = tag;
        write_cmd.addr  = addr;
        write_cmd.btt   = `MEM_BTT_BITS'(btt);
        write_cmd_valid = 1'b1;
        while (!write_cmd_ready) step();
        step();
        write_cmd_valid = 1'b0;
        for (int w = 0; w < words; w++) begin
            if (rand_ready) repeat ($urandom % 3) step();
            // fill word carries its own word index
            beat.data = fill ? {32'h600d_0000 | (addr / 8 + w), ~(addr / 8 + w)}
                             : {$urandom, $urandom};
            beat.keep = rand_keep ? 8'($urandom) : '1;
            beat.last = (w == words - 1);
            write_data       = beat;
            write_data_valid = 1'b1;
            while (!write_data_ready) step();
            step();
            write_data_valid = 1'b0;
        end
        while (wsts_done != target) step();
    endtask

    task automatic read_burst(input logic [31:0] addr, input int btt,
                              input logic [`MEM_TAG_BITS-1:0] tag);
        int target;
        target         = rsts_done + 1;
        read_cmd       = '0;
        read_cmd.tag   = tag;
        read_cmd.addr  = addr;
        read_cmd.btt   = `MEM_BTT_BITS'(btt);
        read_cmd_valid = 1'b1;
        while (!read_cmd_ready) step();
        step();
        read_cmd_valid = 1'b0;
        while (rsts_done != target) step();
    endtask

    initial begin
        void'($urandom(28));
        arst_n           = 1'b0;
        write_cmd        = '0;
        write_cmd_valid  = 1'b0;
        write_data       = '0;
        write_data_valid = 1'b0;
        read_cmd         = '0;
        read_cmd_valid   = 1'b0;
        repeat (4) @(posedge c0_ui_clk);
        #0.5;
        arst_n = 1'b1;
        step();

        // whole store filled, then full-word read back
        write_burst(32'd0, MODEL_BYTES, 4'd1, 1'b0, 1'b1);
        read_burst(32'd64, 128, 4'd2);
        // lengths not a multiple of the word
        read_burst(32'd160, 13, 4'd3);
        read_burst(32'd240, 21, 4'd4);
        read_burst(32'd320, 5, 4'd5);
        read_burst(32'd328, 8, 4'd6);
        // partial keep over filled words
        write_burst(32'd256, 32, 4'd7, 1'b1, 1'b0);
        read_burst(32'd248, 48, 4'd8);

        rand_ready = 1'b1;
        for (int i = 0; i < 12; i++) begin
            if (i % 3 == 0) begin
                write_burst(8 * ($urandom % 240), 1 + $urandom % 128, 4'(i), 1'b1, 1'b0);
            end
            read_burst(8 * ($urandom % 240), 1 + $urandom % 128, 4'(i + 1));
        end

        // past the end of the store, then zero length
        write_burst(32'd2000, 64, 4'd9, 1'b0, 1'b0);
        read_burst(32'd1984, 64, 4'd10);
        read_burst(32'd2016, 40, 4'd11);
        write_burst(32'd80, 0, 4'd12, 1'b0, 1'b0);
        read_burst(32'd80, 0, 4'd13);
        rand_ready = 1'b0;
        repeat (4) step();

        if (exp_beat_q.size() != 0 || exp_wsts_q.size() != 0 || exp_rsts_q.size() != 0) begin
            $display("beats or status still outstanding at end of run");
            abort_run();
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

// File: project.f
+incdir+.
mem_if_pkg.sv
mem_write_engine.sv
word_store.sv
mem_read_engine.sv
mem_if_top.sv
tb_mem_if.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_if
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
